/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_tile_layer
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* render_pkg.sv */
// Shared types of the tile layer pixel engine: register sets,
// VRAM requests, render requests and results, renderer states
`include "tile_defines.svh"

package render_pkg;

  // Index 0 (ctrl0) sits in the low 16 bits, so register i is at bits [16*i +: 16]
  typedef struct packed {
    logic [`REG_DATA_WIDTH-1:0] offset_y;
    logic [`REG_DATA_WIDTH-1:0] offset_x;
    logic [`REG_DATA_WIDTH-1:0] color_key;
    logic [`REG_DATA_WIDTH-1:0] nop_value;
    logic [`REG_DATA_WIDTH-1:0] data_offset;
    logic [`REG_DATA_WIDTH-1:0] ctrl1;
    logic [`REG_DATA_WIDTH-1:0] ctrl0;
  } tile_regs_t;

  typedef struct packed {
    logic                       layer_enabled;
    logic                       enable_nop;
    logic                       enable_scroll;
    logic                       enable_transp;
    logic                       enable_wrap_x;
    logic                       enable_wrap_y;
    logic [`REG_DATA_WIDTH-1:0] data_offset;
    logic [`REG_DATA_WIDTH-1:0] nop_value;
    logic [`REG_DATA_WIDTH-1:0] color_key;
    logic [`REG_DATA_WIDTH-1:0] offset_x;
    logic [`REG_DATA_WIDTH-1:0] offset_y;
  } layer_cfg_t;

  typedef struct packed {
    logic                        valid;
    logic                        write;
    logic [`VRAM_ADDR_WIDTH-1:0] addr;
    logic [`REG_DATA_WIDTH-1:0]  wdata;
  } vram_req_t;

  typedef struct packed {
    logic [`LAYER_SEL_WIDTH-1:0] layer;
    logic [`COORD_WIDTH-1:0]     x;
    logic [`COORD_WIDTH-1:0]     y;
  } render_req_t;

  typedef struct packed {
    logic [`PIXEL_WIDTH-1:0] pixel;
    logic                    transparent;
  } render_result_t;

  typedef enum logic [2:0] {
    idle,
    map_read,
    map_wait,
    tile_read,
    tile_wait,
    done
  } render_state_e;

endpackage

/* src.f */
+incdir+.
render_pkg.sv
tile_reg_file.sv
tile_reg_decoder.sv
vram.sv
vram_arbiter.sv
tile_pixel_renderer.sv
tile_layer_top.sv
tb_tile_layer.sv

/* tb_tile_layer.sv */
// Testbench for the tile layer pixel engine
// Mirrors VRAM and the layer registers and checks every rendered pixel against a model
`timescale 1ns/1ps
`include "tile_defines.svh"

module tb_tile_layer;
  import render_pkg::*;

  localparam logic [15:0] ctl_en     = 16'(1 << `TILE_LAYER_ENABLED);
  localparam logic [15:0] ctl_nop    = 16'(1 << `TILE_ENABLE_NOP);
  localparam logic [15:0] ctl_scroll = 16'(1 << `TILE_ENABLE_SCROLL);
  localparam logic [15:0] ctl_transp = 16'(1 << `TILE_ENABLE_TRANSP);
  localparam logic [15:0] ctl_wrap   = 16'((1 << `TILE_ENABLE_WRAP_X) | (1 << `TILE_ENABLE_WRAP_Y));

  logic                        clk;
  logic                        rst_n;
  logic                        reg_we;
  logic [`LAYER_SEL_WIDTH-1:0] reg_layer;
  logic [`REG_INDEX_WIDTH-1:0] reg_index;
  logic [`REG_DATA_WIDTH-1:0]  reg_wdata;
  logic                        host_we;
  logic [`VRAM_ADDR_WIDTH-1:0] host_addr;
  logic [`REG_DATA_WIDTH-1:0]  host_wdata;
  logic                        render_start;
  render_req_t                 render_req;
  logic                        pix_valid;
  render_result_t              pix_result;

  logic [15:0]    vram_model [`VRAM_DEPTH];
  logic [15:0]    reg_model [`NUM_TILE_LAYERS][`NUM_TILE_REGISTERS];
  integer         seed;
  logic           pending;
  render_result_t exp_res;
  bit             exp_early;

  tile_layer_top dut (
    .clk(clk), .rst_n(rst_n),
    .reg_we(reg_we), .reg_layer(reg_layer), .reg_index(reg_index), .reg_wdata(reg_wdata),
    .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
    .render_start(render_start), .render_req(render_req),
    .pix_valid(pix_valid), .pix_result(pix_result)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, want);
    $display("test failed");
    $fatal(1);
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) pix_valid |-> pending)
    else abort_run("pix_valid pulsed with no render request pending");
  assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !pix_valid)
    else abort_run("pix_valid was high during or right after reset");
  assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid |-> (pix_result.transparent == exp_res.transparent)
                  && (exp_res.transparent || pix_result.pixel == exp_res.pixel))
    else report_mismatch("pix_result", 32'(pix_result), 32'(exp_res));

  function automatic int map_index(input int offset, input int x, input int y);
    return (offset + (y / `TILE_SIZE) * `MAP_TILES + x / `TILE_SIZE) % `VRAM_DEPTH;
  endfunction

  function automatic int pixel_index(input int tile, input int x, input int y);
    return 32'(`TILE_DATA_BASE) + tile * `TILE_SIZE * `TILE_SIZE
           + (y % `TILE_SIZE) * `TILE_SIZE + x % `TILE_SIZE;
  endfunction

  // Reference pixel; early is set when the renderer should skip both VRAM reads
  function automatic render_result_t model_pixel(input int layer, input int x, input int y,
                                                 output bit early);
    logic [15:0]    ctrl0;
    logic [15:0]    word;
    logic [7:0]     pix;
    int             sx;
    int             sy;
    render_result_t r;
    ctrl0 = reg_model[layer][`TILE_CTRL0];
    r     = '0;
    early = 1'b0;
    sx    = x;
    sy    = y;
    if (ctrl0[`TILE_ENABLE_SCROLL]) begin
      sx = sx + int'(reg_model[layer][`TILE_OFFSET_X]);
      sy = sy + int'(reg_model[layer][`TILE_OFFSET_Y]);
    end
    if (sx >= `MAP_PIXELS) begin
      if (ctrl0[`TILE_ENABLE_WRAP_X]) sx = sx % `MAP_PIXELS;
      else early = 1'b1;
    end
    if (sy >= `MAP_PIXELS) begin
      if (ctrl0[`TILE_ENABLE_WRAP_Y]) sy = sy % `MAP_PIXELS;
      else early = 1'b1;
    end
    if (!ctrl0[`TILE_LAYER_ENABLED]) early = 1'b1;
    if (early) begin
      r.transparent = 1'b1;
      return r;
    end
    word = vram_model[map_index(int'(reg_model[layer][`TILE_DATA_OFFSET]), sx, sy)];
    if (ctrl0[`TILE_ENABLE_NOP] && word == reg_model[layer][`TILE_NOP_VALUE]) begin
      r.transparent = 1'b1;
      return r;
    end
    pix = vram_model[pixel_index(int'(word[3:0]), sx, sy)][7:0];
    r.pixel = pix;
    r.transparent = ctrl0[`TILE_ENABLE_TRANSP] && pix == reg_model[layer][`TILE_COLOR_KEY][7:0];
    return r;
  endfunction

  // Advance one clock and drop every strobe shortly after the edge
  task automatic drive_step();
    @(posedge clk);
    #2;
    reg_we       = 1'b0;
    host_we      = 1'b0;
    render_start = 1'b0;
  endtask

  task automatic write_reg(input int layer, input int idx, input logic [15:0] data);
    drive_step();
    reg_we    = 1'b1;
    reg_layer = 2'(layer);
    reg_index = 3'(idx);
    reg_wdata = data;
    reg_model[layer][idx] = data;
  endtask

  task automatic write_vram(input int addr, input logic [15:0] data);
    drive_step();
    host_we    = 1'b1;
    host_addr  = 12'(addr);
    host_wdata = data;
    vram_model[addr] = data;
  endtask

  task automatic start_render(input int layer, input int x, input int y);
    exp_res = model_pixel(layer, x, y, exp_early);
    drive_step();
    render_start = 1'b1;
    render_req   = '{layer: 2'(layer), x: 8'(x), y: 8'(y)};
    pending      = 1'b1;
  endtask

  task automatic wait_result(output int cycles);
    cycles = 0;
    do begin
      drive_step();
      cycles++;
      if (!pix_valid && cycles >= 200) abort_run("timed out waiting for pix_valid");
    end while (!pix_valid);
    // Keep the request pending through the edge that samples the pulse
    drive_step();
    pending = 1'b0;
  endtask

  task automatic render_check(input int layer, input int x, input int y);
    int lat;
    start_render(layer, x, y);
    wait_result(lat);
    if (exp_early) begin
      assert (lat == 2) else report_mismatch("pix_valid latency", lat, 2);
    end
  endtask

  initial begin
    int ma;
    int pa;
    int x;
    int y;
    int cycles;
    seed = 32'hd0f0;
    rst_n = 1'b0;
    reg_we = 1'b0;
    reg_layer = '0;
    reg_index = '0;
    reg_wdata = '0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    render_start = 1'b0;
    render_req = '0;
    pending = 1'b0;
    exp_res = '0;
    for (int l = 0; l < `NUM_TILE_LAYERS; l++) begin
      for (int r = 0; r < `NUM_TILE_REGISTERS; r++) reg_model[l][r] = '0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Random maps and tile pixels over the whole memory
    for (int a = 0; a < `VRAM_DEPTH; a++) write_vram(a, 16'($random(seed)));

    write_reg(0, `TILE_CTRL0, ctl_en);
    repeat (20) render_check(0, $random(seed) & 255, $random(seed) & 255);

    write_reg(0, `TILE_OFFSET_X, 16'h0030);
    write_reg(0, `TILE_OFFSET_Y, 16'h0050);
    write_reg(0, `TILE_CTRL0, ctl_en | ctl_scroll);
    render_check(0, 8'h10, 8'h20);
    render_check(0, 8'hf0, 8'h10);
    render_check(0, 8'h10, 8'hc0);
    repeat (10) render_check(0, $random(seed) & 255, $random(seed) & 255);
    write_reg(0, `TILE_CTRL0, ctl_en | ctl_scroll | ctl_wrap);
    render_check(0, 8'hf0, 8'hc0);
    repeat (10) render_check(0, $random(seed) & 255, $random(seed) & 255);

    // An offset beyond 511 still wraps modulo 256, or falls off the map without wrap
    write_reg(0, `TILE_OFFSET_X, 16'h0210);
    render_check(0, 8'h10, 8'h20);
    write_reg(0, `TILE_CTRL0, ctl_en | ctl_scroll);
    render_check(0, 8'h10, 8'h20);

    // Nop tile at (16,24), keyed pixel at (32,32)
    write_reg(0, `TILE_CTRL0, ctl_en);
    write_vram(map_index(0, 16, 24), 16'h0abc);
    write_reg(0, `TILE_NOP_VALUE, 16'h0abc);
    render_check(0, 16, 24);
    write_reg(0, `TILE_CTRL0, ctl_en | ctl_nop);
    render_check(0, 16, 24);
    write_vram(map_index(0, 32, 32), 16'h0005);
    write_vram(pixel_index(5, 32, 32), 16'h3377);
    write_reg(0, `TILE_COLOR_KEY, 16'h0077);
    render_check(0, 32, 32);
    write_reg(0, `TILE_CTRL0, ctl_en | ctl_nop | ctl_transp);
    render_check(0, 32, 32);

    for (int l = 0; l < `NUM_TILE_LAYERS; l++) begin
      write_reg(l, `TILE_DATA_OFFSET, 16'(l * 'h100));
      write_reg(l, `TILE_CTRL0, ctl_en);
    end
    repeat (4) begin
      x = $random(seed) & 255;
      y = $random(seed) & 255;
      for (int l = 0; l < `NUM_TILE_LAYERS; l++) render_check(l, x, y);
    end
    write_reg(2, `TILE_CTRL0, 16'h0000);
    render_check(2, 8'h40, 8'h40);

    // Host writes hold the port every cycle, the renderer reads only after them
    ma = map_index(0, 8'h48, 8'h30);
    pa = pixel_index(9, 8'h48, 8'h30);
    vram_model[ma] = 16'h0009;
    vram_model[pa] = 16'h00c3;
    start_render(0, 8'h48, 8'h30);
    for (int i = 0; i < 12; i++) begin
      if (i == 0) write_vram(ma, 16'h0009);
      else if (i == 1) write_vram(pa, 16'h00c3);
      else write_vram('hf00 + i, 16'($random(seed)));
      assert (!pix_valid) else abort_run("pix_valid arrived while host writes held VRAM");
    end
    wait_result(cycles);
    assert (cycles >= 6) else abort_run("renderer finished too soon after the host writes");

    start_render(1, 8'h21, 8'h63);
    drive_step();
    drive_step();
    render_start = 1'b1;
    render_req   = '{layer: 2'd3, x: 8'h99, y: 8'h05};
    wait_result(cycles);
    repeat (20) begin
      drive_step();
      assert (!pix_valid) else abort_run("extra pix_valid after a render strobe while busy");
    end

    $display("test passed");
    $finish;
  end

endmodule

/* tile_defines.svh */
// Tile layer geometry, register map and control bit positions
// shared by the pixel engine and its testbench
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

`define NUM_TILE_LAYERS     4
`define NUM_TILE_REGISTERS  7
`define REG_DATA_WIDTH      16
`define LAYER_SEL_WIDTH     2
`define REG_INDEX_WIDTH     3

// Register indices within one layer
`define TILE_CTRL0          0
`define TILE_CTRL1          1
`define TILE_DATA_OFFSET    2
`define TILE_NOP_VALUE      3
`define TILE_COLOR_KEY      4
`define TILE_OFFSET_X       5
`define TILE_OFFSET_Y       6

// Bit positions in ctrl0
`define TILE_LAYER_ENABLED  0
`define TILE_ENABLE_8_BIT   1
`define TILE_ENABLE_NOP     2
`define TILE_ENABLE_SCROLL  3
`define TILE_ENABLE_TRANSP  4
`define TILE_ENABLE_ALPHA   5
`define TILE_ENABLE_COLOR   6
`define TILE_ENABLE_WRAP_X  7
`define TILE_ENABLE_WRAP_Y  8
`define TILE_ENABLE_FLIP    9

`define VRAM_ADDR_WIDTH     12
`define VRAM_DEPTH          4096
`define TILE_DATA_BASE      12'h800
`define MAP_TILES           32
`define TILE_SIZE           8
`define MAP_PIXELS          (`MAP_TILES * `TILE_SIZE)
`define COORD_WIDTH         8
`define PIXEL_WIDTH         8
`define TILE_NUM_WIDTH      4

`endif

/* tile_layer_top.sv */
// Tile layer pixel engine top level
// Host register and VRAM writes share the memory with the pixel renderer
`timescale 1ns/1ps
`include "tile_defines.svh"

module tile_layer_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        reg_we,
  input  logic [`LAYER_SEL_WIDTH-1:0] reg_layer,
  input  logic [`REG_INDEX_WIDTH-1:0] reg_index,
  input  logic [`REG_DATA_WIDTH-1:0]  reg_wdata,
  input  logic                        host_we,
  input  logic [`VRAM_ADDR_WIDTH-1:0] host_addr,
  input  logic [`REG_DATA_WIDTH-1:0]  host_wdata,
  input  logic                        render_start,
  input  render_pkg::render_req_t     render_req,
  output logic                        pix_valid,
  output render_pkg::render_result_t  pix_result
);
  import render_pkg::*;

  tile_regs_t                  regs [`NUM_TILE_LAYERS];
  layer_cfg_t                  cfg;
  logic [`LAYER_SEL_WIDTH-1:0] cur_layer;
  vram_req_t                   host_req;
  vram_req_t                   render_mem_req;
  vram_req_t                   mem_req;
  logic                        render_grant;
  logic [`REG_DATA_WIDTH-1:0]  rdata;

  // The host strobe is always a write
  assign host_req = '{valid: host_we, write: 1'b1, addr: host_addr, wdata: host_wdata};

  tile_reg_file u_reg_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_we    (reg_we),
    .reg_layer (reg_layer),
    .reg_index (reg_index),
    .reg_wdata (reg_wdata),
    .regs      (regs)
  );

  tile_reg_decoder u_decoder (
    .current_layer (cur_layer),
    .regs          (regs),
    .cfg           (cfg)
  );

  vram_arbiter u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_req     (host_req),
    .render_req   (render_mem_req),
    .render_grant (render_grant),
    .mem_req      (mem_req)
  );

  vram u_vram (
    .clk   (clk),
    .req   (mem_req),
    .rdata (rdata)
  );

  tile_pixel_renderer u_renderer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (render_start),
    .req       (render_req),
    .cfg       (cfg),
    .grant     (render_grant),
    .rdata     (rdata),
    .cur_layer (cur_layer),
    .mem_req   (render_mem_req),
    .valid     (pix_valid),
    .result    (pix_result)
  );

endmodule

/* tile_pixel_renderer.sv */
// Tile pixel renderer
// Turns a layer and screen coordinate into one pixel via a map read and a tile read
`timescale 1ns/1ps
`include "tile_defines.svh"

module tile_pixel_renderer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  render_pkg::render_req_t     req,
  input  render_pkg::layer_cfg_t      cfg,
  input  logic                        grant,
  input  logic [`REG_DATA_WIDTH-1:0]  rdata,
  output logic [`LAYER_SEL_WIDTH-1:0] cur_layer,
  output render_pkg::vram_req_t       mem_req,
  output logic                        valid,
  output render_pkg::render_result_t  result
);
  import render_pkg::*;

  render_state_e               state;
  render_req_t                 req_q;
  logic [`REG_DATA_WIDTH:0]    sum_x;
  logic [`REG_DATA_WIDTH:0]    sum_y;
  logic [`COORD_WIDTH-1:0]     map_x;
  logic [`COORD_WIDTH-1:0]     map_y;
  logic                        skip;
  logic [`VRAM_ADDR_WIDTH-1:0] map_addr;
  logic [`VRAM_ADDR_WIDTH-1:0] tile_addr;
  logic [2:0]                  fine_row_q;
  logic [2:0]                  fine_col_q;
  logic [`TILE_NUM_WIDTH-1:0]  tile_q;
  logic [`PIXEL_WIDTH-1:0]     pix_q;

  assign cur_layer = req_q.layer;

  // Coordinate step, evaluated against the latched request
  always_comb begin
    sum_x = (`REG_DATA_WIDTH+1)'(req_q.x);
    sum_y = (`REG_DATA_WIDTH+1)'(req_q.y);
    if (cfg.enable_scroll) begin
      sum_x = sum_x + (`REG_DATA_WIDTH+1)'(cfg.offset_x);
      sum_y = sum_y + (`REG_DATA_WIDTH+1)'(cfg.offset_y);
    end
    // Keeping only the low 8 bits is the wrap, modulo 256
    map_x = sum_x[`COORD_WIDTH-1:0];
    map_y = sum_y[`COORD_WIDTH-1:0];
    skip  = !cfg.layer_enabled
            || (sum_x >= `MAP_PIXELS && !cfg.enable_wrap_x)
            || (sum_y >= `MAP_PIXELS && !cfg.enable_wrap_y);
  end

  assign map_addr = cfg.data_offset[`VRAM_ADDR_WIDTH-1:0]
                    + `VRAM_ADDR_WIDTH'(map_y / `TILE_SIZE) * `VRAM_ADDR_WIDTH'(`MAP_TILES)
                    + `VRAM_ADDR_WIDTH'(map_x / `TILE_SIZE);

  assign tile_addr = `TILE_DATA_BASE
                     + `VRAM_ADDR_WIDTH'(tile_q) * `VRAM_ADDR_WIDTH'(`TILE_SIZE * `TILE_SIZE)
                     + `VRAM_ADDR_WIDTH'(fine_row_q) * `VRAM_ADDR_WIDTH'(`TILE_SIZE)
                     + `VRAM_ADDR_WIDTH'(fine_col_q);

  // Read requests stay up until the arbiter grants them
  always_comb begin
    mem_req = '0;
    if (state == map_read && !skip) begin
      mem_req.valid = 1'b1;
      mem_req.addr  = map_addr;
    end else if (state == tile_read) begin
      mem_req.valid = 1'b1;
      mem_req.addr  = tile_addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= idle;
      req_q  <= '0;
      valid  <= 1'b0;
      result <= '0;
    end else begin
      valid <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            req_q <= req;
            state <= map_read;
          end
        end
        map_read: begin
          // Disabled layer or off-map coordinate ends early with pixel 0
          if (skip) begin
            result <= '{pixel: '0, transparent: 1'b1};
            valid  <= 1'b1;
            state  <= idle;
          end else if (grant) begin
            state <= map_wait;
          end
        end
        map_wait: begin
          if (cfg.enable_nop && rdata == cfg.nop_value) begin
            result <= '{pixel: '0, transparent: 1'b1};
            valid  <= 1'b1;
            state  <= idle;
          end else begin
            state <= tile_read;
          end
        end
        tile_read: begin
          if (grant) begin
            state <= tile_wait;
          end
        end
        tile_wait: begin
          state <= done;
        end
        done: begin
          // A keyed pixel keeps its value and only gets the transparent flag
          result.pixel       <= pix_q;
          result.transparent <= cfg.enable_transp
                                && pix_q == cfg.color_key[`PIXEL_WIDTH-1:0];
          valid              <= 1'b1;
          state              <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Datapath captures along the map and tile reads
  always_ff @(posedge clk) begin
    if (state == map_read && grant) begin
      fine_row_q <= 3'(map_y % `TILE_SIZE);
      fine_col_q <= 3'(map_x % `TILE_SIZE);
    end
    if (state == map_wait) begin
      tile_q <= rdata[`TILE_NUM_WIDTH-1:0];
    end
    if (state == tile_wait) begin
      pix_q <= rdata[`PIXEL_WIDTH-1:0];
    end
  end

endmodule

/* tile_reg_decoder.sv */
// Tile register field decoder
// Picks one layer's register set and splits out the ctrl0 flags and fields
`timescale 1ns/1ps
`include "tile_defines.svh"

module tile_reg_decoder (
  input  logic [`LAYER_SEL_WIDTH-1:0] current_layer,
  input  render_pkg::tile_regs_t      regs [`NUM_TILE_LAYERS],
  output render_pkg::layer_cfg_t      cfg
);
  import render_pkg::*;

  tile_regs_t                 sel;
  logic [`REG_DATA_WIDTH-1:0] ctrl0;

  function automatic logic [`REG_DATA_WIDTH-1:0] reg_at(tile_regs_t r, int idx);
    return r[idx*`REG_DATA_WIDTH +: `REG_DATA_WIDTH];
  endfunction

  assign sel   = regs[current_layer];
  assign ctrl0 = reg_at(sel, `TILE_CTRL0);

  // 8-bit mode, alpha, colour and flip bits stay in ctrl0 but drive nothing here
  always_comb begin
    cfg.layer_enabled = ctrl0[`TILE_LAYER_ENABLED];
    cfg.enable_nop    = ctrl0[`TILE_ENABLE_NOP];
    cfg.enable_scroll = ctrl0[`TILE_ENABLE_SCROLL];
    cfg.enable_transp = ctrl0[`TILE_ENABLE_TRANSP];
    cfg.enable_wrap_x = ctrl0[`TILE_ENABLE_WRAP_X];
    cfg.enable_wrap_y = ctrl0[`TILE_ENABLE_WRAP_Y];
    cfg.data_offset   = reg_at(sel, `TILE_DATA_OFFSET);
    cfg.nop_value     = reg_at(sel, `TILE_NOP_VALUE);
    cfg.color_key     = reg_at(sel, `TILE_COLOR_KEY);
    cfg.offset_x      = reg_at(sel, `TILE_OFFSET_X);
    cfg.offset_y      = reg_at(sel, `TILE_OFFSET_Y);
  end

endmodule

/* tile_reg_file.sv */
// Tile layer register file
// Holds seven 16-bit registers for each of the four layers
`timescale 1ns/1ps
`include "tile_defines.svh"

module tile_reg_file (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        reg_we,
  input  logic [`LAYER_SEL_WIDTH-1:0] reg_layer,
  input  logic [`REG_INDEX_WIDTH-1:0] reg_index,
  input  logic [`REG_DATA_WIDTH-1:0]  reg_wdata,
  output render_pkg::tile_regs_t      regs [`NUM_TILE_LAYERS]
);

  logic index_ok;

  // Index 7 has no register behind it
  assign index_ok = reg_index < `NUM_TILE_REGISTERS;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_TILE_LAYERS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we && index_ok) begin
      regs[reg_layer][reg_index*`REG_DATA_WIDTH +: `REG_DATA_WIDTH] <= reg_wdata;
    end
  end

endmodule

/* vram.sv */
// Video memory, 4096 x 16, single port
// Writes land at the clock edge, read data is registered and held
`timescale 1ns/1ps
`include "tile_defines.svh"

module vram (
  input  logic                       clk,
  input  render_pkg::vram_req_t      req,
  output logic [`REG_DATA_WIDTH-1:0] rdata
);

  logic [`REG_DATA_WIDTH-1:0] mem [`VRAM_DEPTH];

  // rdata only changes on a read, so a later host write leaves
  // the word the renderer is about to use untouched
  always_ff @(posedge clk) begin
    if (req.valid) begin
      if (req.write) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata <= mem[req.addr];
      end
    end
  end

endmodule

/* vram_arbiter.sv */
// VRAM port arbiter with fixed priority to host writes
// The renderer gets the port only in cycles free of host traffic
`timescale 1ns/1ps

module vram_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  render_pkg::vram_req_t host_req,
  input  render_pkg::vram_req_t render_req,
  output logic                  render_grant,
  output render_pkg::vram_req_t mem_req
);

  // Set while a renderer read word is on its way back from memory
  logic render_rd_busy;

  always_comb begin
    // One renderer read in flight at a time, so the returning word is always its own
    render_grant = render_req.valid && !host_req.valid && !render_rd_busy;

    if (host_req.valid) begin
      mem_req = host_req;
    end else if (render_grant) begin
      mem_req = render_req;
    end else begin
      mem_req = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      render_rd_busy <= 1'b0;
    end else begin
      render_rd_busy <= render_grant && !render_req.write;
    end
  end

endmodule
